// ==== verilog/rvv_pkg.sv ====
`default_nettype none

package rvv_pkg;

  // instruction format
  localparam int INST_WIDTH   = 32;
  localparam int PC_WIDTH     = 32;
  localparam int OPCODE_WIDTH = 7;
  localparam int FUNCT6_WIDTH = 6;
  localparam int FUNCT3_WIDTH = 3;
  localparam int VREG_WIDTH   = 5;

  localparam logic [OPCODE_WIDTH-1:0] OPCODE_LOAD_FP  = 7'b0000111;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_STORE_FP = 7'b0100111;
  localparam logic [OPCODE_WIDTH-1:0] OPCODE_OP_V     = 7'b1010111;

  // vtype
  localparam int VSEW_WIDTH  = 3;
  localparam int VLMUL_WIDTH = 3;

  localparam logic [VSEW_WIDTH-1:0]  SEW_8         = 3'b000;
  localparam logic [VSEW_WIDTH-1:0]  SEW_16        = 3'b001;
  localparam logic [VSEW_WIDTH-1:0]  SEW_32        = 3'b010;
  localparam logic [VLMUL_WIDTH-1:0] LMUL_RESERVED = 3'b100;   // others are signed log2 lmul

  // width field of unit-stride loads and stores
  localparam logic [FUNCT3_WIDTH-1:0] WIDTH_E8  = 3'b000;
  localparam logic [FUNCT3_WIDTH-1:0] WIDTH_E16 = 3'b101;
  localparam logic [FUNCT3_WIDTH-1:0] WIDTH_E32 = 3'b110;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  localparam int UOP_INDEX_WIDTH = 3;   // up to 8 registers per group

endpackage

`default_nettype wire

// ==== verilog/rvv_uop_pkg.sv ====
`default_nettype none

package rvv_uop_pkg;

  // which decoder produced the uop
  localparam logic UNIT_LSU = 1'b0;
  localparam logic UNIT_ALU = 1'b1;

  typedef struct packed {
    logic [rvv_pkg::PC_WIDTH-1:0]        pc;
    logic                                unit;
    logic [rvv_pkg::FUNCT6_WIDTH-1:0]    funct6;
    logic [rvv_pkg::FUNCT3_WIDTH-1:0]    funct3;
    logic                                vm;
    logic [rvv_pkg::VREG_WIDTH-1:0]      vd;       // offset by index
    logic [rvv_pkg::VREG_WIDTH-1:0]      vs2;
    logic [rvv_pkg::VREG_WIDTH-1:0]      vs1;
    rvv_pkg::eew_e                       eew;
    logic [rvv_pkg::UOP_INDEX_WIDTH-1:0] index;
    logic                                last;     // final uop of the group
  } uop_t;

endpackage

`default_nettype wire

// ==== verilog/rvv_inst_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_inst_dispatch (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            inst_valid,
  input  logic [rvv_pkg::INST_WIDTH-1:0]  inst,
  input  logic [rvv_pkg::PC_WIDTH-1:0]    inst_pc,
  input  logic                            vill,
  input  logic [rvv_pkg::VSEW_WIDTH-1:0]  vsew,
  input  logic [rvv_pkg::VLMUL_WIDTH-1:0] vlmul,
  input  logic                            lsu_busy,
  input  logic                            alu_busy,
  output logic                            inst_busy,
  output logic                            dispatch_illegal,
  output logic                            lsu_start,
  output logic                            alu_start,
  output logic [rvv_pkg::INST_WIDTH-1:0]  out_inst,
  output logic [rvv_pkg::PC_WIDTH-1:0]    out_pc,
  output logic                            out_vill,
  output logic [rvv_pkg::VSEW_WIDTH-1:0]  out_vsew,
  output logic [rvv_pkg::VLMUL_WIDTH-1:0] out_vlmul
);
  import rvv_pkg::*;

  logic [OPCODE_WIDTH-1:0] opcode;
  logic                    op_lsu;
  logic                    op_alu;
  logic                    take;
  logic                    to_alu;    // target of the held instruction

  assign opcode = inst[6:0];
  assign op_lsu = (opcode == OPCODE_LOAD_FP) || (opcode == OPCODE_STORE_FP);
  assign op_alu = opcode == OPCODE_OP_V;
  assign take   = inst_valid && !inst_busy;

  // release once the target decoder is idle
  assign lsu_start = inst_busy && !to_alu && !lsu_busy;
  assign alu_start = inst_busy && to_alu && !alu_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      inst_busy        <= 1'b0;
      dispatch_illegal <= 1'b0;
      to_alu           <= 1'b0;
    end else begin
      dispatch_illegal <= take && !op_lsu && !op_alu;   // unknown opcode, dropped
      if (take) begin
        inst_busy <= op_lsu || op_alu;
        to_alu    <= op_alu;
      end else if (lsu_start || alu_start) begin
        inst_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_inst  <= inst;
      out_pc    <= inst_pc;
      out_vill  <= vill;
      out_vsew  <= vsew;
      out_vlmul <= vlmul;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rvv_decode_unit_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_unit_lsu (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  logic [rvv_pkg::INST_WIDTH-1:0]  inst,
  input  logic [rvv_pkg::PC_WIDTH-1:0]    pc,
  input  logic                            vill,
  input  logic [rvv_pkg::VSEW_WIDTH-1:0]  vsew,
  input  logic [rvv_pkg::VLMUL_WIDTH-1:0] vlmul,
  input  logic                            grant,
  output logic                            busy,
  output logic                            illegal,
  output logic                            req,
  output rvv_uop_pkg::uop_t               req_uop
);
  import rvv_pkg::*;
  import rvv_uop_pkg::*;

  logic [FUNCT3_WIDTH-1:0]    width;       // encoding[14:12]
  logic signed [3:0]          lmul_log;
  logic signed [3:0]          sew_log;
  logic signed [3:0]          eew_log;
  logic signed [3:0]          emul_log;
  logic                       width_ok;
  logic                       sew_ok;
  logic                       legal;
  logic [1:0]                 count_log;
  logic [UOP_INDEX_WIDTH-1:0] last_idx;

  logic [INST_WIDTH-1:0]      inst_q;
  logic [PC_WIDTH-1:0]        pc_q;
  eew_e                       eew_q;
  logic [UOP_INDEX_WIDTH-1:0] last_idx_q;
  logic [UOP_INDEX_WIDTH-1:0] index;

  assign width = inst[14:12];

  always_comb begin
    width_ok = 1'b1;
    eew_log  = 4'sd0;
    case (width)
      WIDTH_E8:  eew_log = 4'sd0;
      WIDTH_E16: eew_log = 4'sd1;
      WIDTH_E32: eew_log = 4'sd2;
      default:   width_ok = 1'b0;
    endcase
  end

  assign sew_ok   = (vsew == SEW_8) || (vsew == SEW_16) || (vsew == SEW_32);
  assign sew_log  = {2'b00, vsew[1:0]};
  assign lmul_log = {vlmul[2], vlmul};   // vlmul is log2 lmul in two's complement
  assign emul_log = lmul_log + eew_log - sew_log;

  assign legal = !vill && width_ok && sew_ok && (vlmul != LMUL_RESERVED) &&
                 (emul_log >= -4'sd3) && (emul_log <= 4'sd3);

  // fractional emul still takes one register
  assign count_log = emul_log[3] ? 2'd0 : emul_log[1:0];
  assign last_idx  = UOP_INDEX_WIDTH'((4'd1 << count_log) - 4'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      illegal <= 1'b0;
      index   <= '0;
    end else begin
      illegal <= start && !legal;
      if (start) begin
        busy  <= legal;
        index <= '0;
      end else if (grant) begin
        index <= index + 1'b1;
        if (index == last_idx_q) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      inst_q     <= inst;
      pc_q       <= pc;
      eew_q      <= eew_e'(eew_log[1:0]);
      last_idx_q <= last_idx;
    end
  end

  assign req = busy;

  always_comb begin
    req_uop.pc     = pc_q;
    req_uop.unit   = UNIT_LSU;
    req_uop.funct6 = inst_q[31:26];
    req_uop.funct3 = inst_q[14:12];
    req_uop.vm     = inst_q[25];
    req_uop.vd     = inst_q[11:7] + VREG_WIDTH'(index);   // wraps past v31
    req_uop.vs2    = inst_q[24:20];
    req_uop.vs1    = inst_q[19:15];
    req_uop.eew    = eew_q;
    req_uop.index  = index;
    req_uop.last   = index == last_idx_q;
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
    else $error("lsu decoder started while busy");

endmodule

`default_nettype wire

// ==== verilog/rvv_decode_unit_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_unit_alu (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            start,
  input  logic [rvv_pkg::INST_WIDTH-1:0]  inst,
  input  logic [rvv_pkg::PC_WIDTH-1:0]    pc,
  input  logic                            vill,
  input  logic [rvv_pkg::VSEW_WIDTH-1:0]  vsew,
  input  logic [rvv_pkg::VLMUL_WIDTH-1:0] vlmul,
  input  logic                            grant,
  output logic                            busy,
  output logic                            illegal,
  output logic                            req,
  output rvv_uop_pkg::uop_t               req_uop
);
  import rvv_pkg::*;
  import rvv_uop_pkg::*;

  logic                       sew_ok;
  logic                       legal;
  logic [1:0]                 count_log;
  logic [UOP_INDEX_WIDTH-1:0] last_idx;

  logic [INST_WIDTH-1:0]      inst_q;
  logic [PC_WIDTH-1:0]        pc_q;
  eew_e                       eew_q;
  logic [UOP_INDEX_WIDTH-1:0] last_idx_q;
  logic [UOP_INDEX_WIDTH-1:0] index;

  assign sew_ok = (vsew == SEW_8) || (vsew == SEW_16) || (vsew == SEW_32);
  assign legal  = !vill && sew_ok && (vlmul != LMUL_RESERVED);

  // negative vlmul is fractional, one register
  assign count_log = vlmul[2] ? 2'd0 : vlmul[1:0];
  assign last_idx  = UOP_INDEX_WIDTH'((4'd1 << count_log) - 4'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      illegal <= 1'b0;
      index   <= '0;
    end else begin
      illegal <= start && !legal;
      if (start) begin
        busy  <= legal;
        index <= '0;
      end else if (grant) begin
        index <= index + 1'b1;
        if (index == last_idx_q) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      inst_q     <= inst;
      pc_q       <= pc;
      eew_q      <= eew_e'(vsew[1:0]);   // eew follows sew
      last_idx_q <= last_idx;
    end
  end

  assign req = busy;

  always_comb begin
    req_uop.pc     = pc_q;
    req_uop.unit   = UNIT_ALU;
    req_uop.funct6 = inst_q[31:26];
    req_uop.funct3 = inst_q[14:12];
    req_uop.vm     = inst_q[25];
    req_uop.vd     = inst_q[11:7] + VREG_WIDTH'(index);
    req_uop.vs2    = inst_q[24:20];
    req_uop.vs1    = inst_q[19:15];
    req_uop.eew    = eew_q;
    req_uop.index  = index;
    req_uop.last   = index == last_idx_q;
  end

  a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy)
    else $error("alu decoder started while busy");

endmodule

`default_nettype wire

// ==== verilog/rvv_uop_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_uop_arbiter (
  input  logic              clk,
  input  logic              reset,
  input  logic              lsu_req,
  input  rvv_uop_pkg::uop_t lsu_uop,
  input  logic              alu_req,
  input  rvv_uop_pkg::uop_t alu_uop,
  input  logic              full,
  output logic              lsu_grant,
  output logic              alu_grant,
  output logic              push,
  output rvv_uop_pkg::uop_t push_uop
);

  logic last_alu;   // alu won the previous contested slot

  // lsu has priority right after reset
  assign lsu_grant = !full && lsu_req && (!alu_req || last_alu);
  assign alu_grant = !full && alu_req && (!lsu_req || !last_alu);

  assign push     = lsu_grant || alu_grant;
  assign push_uop = alu_grant ? alu_uop : lsu_uop;

  always_ff @(posedge clk) begin
    if (reset) begin
      last_alu <= 1'b1;
    end else if (push) begin
      last_alu <= alu_grant;
    end
  end

  a_lsu_req_held: assert property (@(posedge clk) disable iff (reset)
                                   lsu_req && !lsu_grant |=> lsu_req)
    else $error("lsu request dropped before grant");

  a_alu_req_held: assert property (@(posedge clk) disable iff (reset)
                                   alu_req && !alu_grant |=> alu_req)
    else $error("alu request dropped before grant");

endmodule

`default_nettype wire

// ==== verilog/rvv_uop_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_uop_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  rvv_uop_pkg::uop_t push_uop,
  input  logic              pop,
  output logic              full,
  output logic              head_valid,
  output rvv_uop_pkg::uop_t head_uop
);
  import rvv_uop_pkg::*;

  localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

  uop_t                 mem [QUEUE_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   count;
  logic                 pop_en;

  assign full       = count == (PTR_WIDTH+1)'(QUEUE_DEPTH);
  assign head_valid = count != '0;
  assign head_uop   = mem[rd_ptr];
  assign pop_en     = pop && head_valid;   // pop on empty is ignored

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !full)
    else $error("push into full uop queue");

endmodule

`default_nettype wire

// ==== verilog/rvv_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvv_decode_top #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                inst_valid,
  input  logic [rvv_pkg::INST_WIDTH-1:0]      inst,
  input  logic [rvv_pkg::PC_WIDTH-1:0]        inst_pc,
  input  logic                                vill,
  input  logic [rvv_pkg::VSEW_WIDTH-1:0]      vsew,
  input  logic [rvv_pkg::VLMUL_WIDTH-1:0]     vlmul,
  input  logic                                uop_pop,
  output logic                                inst_busy,
  output logic                                dispatch_illegal,
  output logic                                lsu_illegal,
  output logic                                alu_illegal,
  output logic                                uop_valid,
  output logic [rvv_pkg::PC_WIDTH-1:0]        uop_pc,
  output logic                                uop_unit,
  output logic [rvv_pkg::FUNCT6_WIDTH-1:0]    uop_funct6,
  output logic [rvv_pkg::FUNCT3_WIDTH-1:0]    uop_funct3,
  output logic                                uop_vm,
  output logic [rvv_pkg::VREG_WIDTH-1:0]      uop_vd,
  output logic [rvv_pkg::VREG_WIDTH-1:0]      uop_vs2,
  output logic [rvv_pkg::VREG_WIDTH-1:0]      uop_vs1,
  output rvv_pkg::eew_e                       uop_eew,
  output logic [rvv_pkg::UOP_INDEX_WIDTH-1:0] uop_index,
  output logic                                uop_last
);
  import rvv_pkg::*;
  import rvv_uop_pkg::*;

  // dispatch to decoders
  logic                   lsu_start;
  logic                   alu_start;
  logic                   lsu_busy;
  logic                   alu_busy;
  logic [INST_WIDTH-1:0]  disp_inst;
  logic [PC_WIDTH-1:0]    disp_pc;
  logic                   disp_vill;
  logic [VSEW_WIDTH-1:0]  disp_vsew;
  logic [VLMUL_WIDTH-1:0] disp_vlmul;

  // decoders to arbiter to queue
  logic lsu_req;
  logic alu_req;
  logic lsu_grant;
  logic alu_grant;
  logic push;
  logic full;
  uop_t lsu_uop;
  uop_t alu_uop;
  uop_t push_uop;
  uop_t head_uop;

  rvv_inst_dispatch i_dispatch (
    .clk              (clk),
    .reset            (reset),
    .inst_valid       (inst_valid),
    .inst             (inst),
    .inst_pc          (inst_pc),
    .vill             (vill),
    .vsew             (vsew),
    .vlmul            (vlmul),
    .lsu_busy         (lsu_busy),
    .alu_busy         (alu_busy),
    .inst_busy        (inst_busy),
    .dispatch_illegal (dispatch_illegal),
    .lsu_start        (lsu_start),
    .alu_start        (alu_start),
    .out_inst         (disp_inst),
    .out_pc           (disp_pc),
    .out_vill         (disp_vill),
    .out_vsew         (disp_vsew),
    .out_vlmul        (disp_vlmul)
  );

  rvv_decode_unit_lsu i_lsu (
    .clk     (clk),
    .reset   (reset),
    .start   (lsu_start),
    .inst    (disp_inst),
    .pc      (disp_pc),
    .vill    (disp_vill),
    .vsew    (disp_vsew),
    .vlmul   (disp_vlmul),
    .grant   (lsu_grant),
    .busy    (lsu_busy),
    .illegal (lsu_illegal),
    .req     (lsu_req),
    .req_uop (lsu_uop)
  );

  rvv_decode_unit_alu i_alu (
    .clk     (clk),
    .reset   (reset),
    .start   (alu_start),
    .inst    (disp_inst),
    .pc      (disp_pc),
    .vill    (disp_vill),
    .vsew    (disp_vsew),
    .vlmul   (disp_vlmul),
    .grant   (alu_grant),
    .busy    (alu_busy),
    .illegal (alu_illegal),
    .req     (alu_req),
    .req_uop (alu_uop)
  );

  rvv_uop_arbiter i_arbiter (
    .clk       (clk),
    .reset     (reset),
    .lsu_req   (lsu_req),
    .lsu_uop   (lsu_uop),
    .alu_req   (alu_req),
    .alu_uop   (alu_uop),
    .full      (full),
    .lsu_grant (lsu_grant),
    .alu_grant (alu_grant),
    .push      (push),
    .push_uop  (push_uop)
  );

  rvv_uop_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_queue (
    .clk        (clk),
    .reset      (reset),
    .push       (push),
    .push_uop   (push_uop),
    .pop        (uop_pop),
    .full       (full),
    .head_valid (uop_valid),
    .head_uop   (head_uop)
  );

  // queue head onto loose ports
  assign uop_pc     = head_uop.pc;
  assign uop_unit   = head_uop.unit;
  assign uop_funct6 = head_uop.funct6;
  assign uop_funct3 = head_uop.funct3;
  assign uop_vm     = head_uop.vm;
  assign uop_vd     = head_uop.vd;
  assign uop_vs2    = head_uop.vs2;
  assign uop_vs1    = head_uop.vs1;
  assign uop_eew    = head_uop.eew;
  assign uop_index  = head_uop.index;
  assign uop_last   = head_uop.last;

endmodule

`default_nettype wire

// ==== test/tb_rvv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rvv_decode;
  import rvv_pkg::*;
  import rvv_uop_pkg::*;

  localparam int BUSY_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 3000;
  localparam logic [2:0] WIDTH_CODES [3] = '{3'b000, 3'b101, 3'b110};
  localparam logic [2:0] LMUL_CODES [7] = '{3'b101, 3'b110, 3'b111, 3'b000,
                                              3'b001, 3'b010, 3'b011};

  logic                       clk;
  logic                       reset;
  logic                       inst_valid;
  logic [INST_WIDTH-1:0]      inst;
  logic [PC_WIDTH-1:0]        inst_pc;
  logic                       vill;
  logic [VSEW_WIDTH-1:0]      vsew;
  logic [VLMUL_WIDTH-1:0]     vlmul;
  logic                       uop_pop;
  logic                       inst_busy;
  logic                       dispatch_illegal;
  logic                       lsu_illegal;
  logic                       alu_illegal;
  logic                       uop_valid;
  logic [PC_WIDTH-1:0]        uop_pc;
  logic                       uop_unit;
  logic [FUNCT6_WIDTH-1:0]    uop_funct6;
  logic [FUNCT3_WIDTH-1:0]    uop_funct3;
  logic                       uop_vm;
  logic [VREG_WIDTH-1:0]      uop_vd;
  logic [VREG_WIDTH-1:0]      uop_vs2;
  logic [VREG_WIDTH-1:0]      uop_vs1;
  eew_e                       uop_eew;
  logic [UOP_INDEX_WIDTH-1:0] uop_index;
  logic                       uop_last;

  int          seed;
  logic        hold_pop;
  logic        next_pop;
  logic [31:0] pc_next;
  uop_t        exp_lsu [$];   // expected uops in program order, per unit
  uop_t        exp_alu [$];
  int          exp_disp_ill;
  int          exp_lsu_ill;
  int          exp_alu_ill;
  int          got_disp_ill;
  int          got_lsu_ill;
  int          got_alu_ill;
  int          value_errors;
  int          illegal_errors;
  int          timeout_errors;

  rvv_decode_top #(
    .QUEUE_DEPTH (4)
  ) i_dut (
    .clk              (clk),
    .reset            (reset),
    .inst_valid       (inst_valid),
    .inst             (inst),
    .inst_pc          (inst_pc),
    .vill             (vill),
    .vsew             (vsew),
    .vlmul            (vlmul),
    .uop_pop          (uop_pop),
    .inst_busy        (inst_busy),
    .dispatch_illegal (dispatch_illegal),
    .lsu_illegal      (lsu_illegal),
    .alu_illegal      (alu_illegal),
    .uop_valid        (uop_valid),
    .uop_pc           (uop_pc),
    .uop_unit         (uop_unit),
    .uop_funct6       (uop_funct6),
    .uop_funct3       (uop_funct3),
    .uop_vm           (uop_vm),
    .uop_vd           (uop_vd),
    .uop_vs2          (uop_vs2),
    .uop_vs1          (uop_vs1),
    .uop_eew          (uop_eew),
    .uop_index        (uop_index),
    .uop_last         (uop_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // legality, group size and eew from the vtype and width rules
  function automatic logic decode_ref(input logic [31:0] word, input logic vill_in,
                                      input logic [2:0] vsew_in, input logic [2:0] vlmul_in,
                                      output int count, output eew_e eew);
    int   sew_log;
    int   lmul_log;
    int   eew_log;
    int   emul_log;
    logic ok;
    ok       = !vill_in;
    sew_log  = 0;
    lmul_log = 0;
    eew_log  = 0;
    case (vsew_in)
      3'b000:  sew_log = 0;
      3'b001:  sew_log = 1;
      3'b010:  sew_log = 2;
      default: ok = 1'b0;
    endcase
    case (vlmul_in)
      3'b101:  lmul_log = -3;
      3'b110:  lmul_log = -2;
      3'b111:  lmul_log = -1;
      3'b000:  lmul_log = 0;
      3'b001:  lmul_log = 1;
      3'b010:  lmul_log = 2;
      3'b011:  lmul_log = 3;
      default: ok = 1'b0;
    endcase
    if (word[6:0] == OPCODE_OP_V) begin
      eew_log  = sew_log;
      emul_log = lmul_log;
    end else begin
      case (word[14:12])
        3'b000:  eew_log = 0;
        3'b101:  eew_log = 1;
        3'b110:  eew_log = 2;
        default: ok = 1'b0;
      endcase
      emul_log = lmul_log + eew_log - sew_log;
      if (emul_log < -3 || emul_log > 3) ok = 1'b0;
    end
    count = (emul_log > 0) ? (1 << emul_log) : 1;
    eew   = (eew_log == 2) ? EEW32 : ((eew_log == 1) ? EEW16 : EEW8);
    return ok;
  endfunction

  task automatic finish_run();
    $display("error counts: value %0d, illegal %0d, timeout %0d",
             value_errors, illegal_errors, timeout_errors);
    if (value_errors == 0 && illegal_errors == 0 && timeout_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_inst(input logic [31:0] word, input logic vill_in,
                           input logic [2:0] vsew_in, input logic [2:0] vlmul_in);
    int   count;
    int   n;
    eew_e eew;
    logic legal;
    logic is_lsu;
    logic is_alu;
    uop_t u;
    is_lsu = (word[6:0] == OPCODE_LOAD_FP) || (word[6:0] == OPCODE_STORE_FP);
    is_alu = word[6:0] == OPCODE_OP_V;
    legal  = decode_ref(word, vill_in, vsew_in, vlmul_in, count, eew);
    if (!is_lsu && !is_alu) begin
      exp_disp_ill++;
    end else if (!legal) begin
      if (is_lsu) exp_lsu_ill++;
      else exp_alu_ill++;
    end else begin
      for (int i = 0; i < count; i++) begin
        u.pc     = pc_next;
        u.unit   = is_alu ? UNIT_ALU : UNIT_LSU;
        u.funct6 = word[31:26];
        u.funct3 = word[14:12];
        u.vm     = word[25];
        u.vd     = word[11:7] + 5'(i);   // wraps modulo 32
        u.vs2    = word[24:20];
        u.vs1    = word[19:15];
        u.eew    = eew;
        u.index  = 3'(i);
        u.last   = i == count - 1;
        if (is_alu) exp_alu.push_back(u);
        else exp_lsu.push_back(u);
      end
    end
    n = 0;
    while (inst_busy) begin
      if (n == BUSY_LIMIT) begin
        $display("timeout at %0t: instruction buffer never became free", $time);
        timeout_errors++;
        finish_run();
      end
      next_cycle();
      n++;
    end
    inst_valid = 1'b1;
    inst       = word;
    inst_pc    = pc_next;
    vill       = vill_in;
    vsew       = vsew_in;
    vlmul      = vlmul_in;
    next_cycle();
    inst_valid = 1'b0;
    pc_next    = pc_next + 32'd4;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_lsu.size() != 0 || exp_alu.size() != 0 || uop_valid || inst_busy) begin
      if (n == DRAIN_LIMIT) begin
        $display("timeout at %0t: uops never drained, %0d lsu and %0d alu still expected",
                 $time, exp_lsu.size(), exp_alu.size());
        timeout_errors++;
        finish_run();
      end
      next_cycle();
      n++;
    end
    repeat (3) next_cycle();   // late illegal pulses
  endtask

  task automatic check_uop();
    uop_t want;
    logic have;
    have = 1'b0;
    if (uop_unit == UNIT_ALU && exp_alu.size() != 0) begin
      want = exp_alu.pop_front();
      have = 1'b1;
    end else if (uop_unit == UNIT_LSU && exp_lsu.size() != 0) begin
      want = exp_lsu.pop_front();
      have = 1'b1;
    end
    if (!have) begin
      $display("FAIL %0t: unexpected uop from unit %0d pc %h", $time, uop_unit, uop_pc);
      value_errors++;
    end else begin
      if (uop_pc !== want.pc || uop_funct6 !== want.funct6 || uop_funct3 !== want.funct3 ||
          uop_vm !== want.vm || uop_vs2 !== want.vs2 || uop_vs1 !== want.vs1) begin
        $display("FAIL %0t: unit %0d got pc %h f6 %h f3 %h vm %b vs2 %0d vs1 %0d, want pc %h",
                 $time, uop_unit, uop_pc, uop_funct6, uop_funct3, uop_vm, uop_vs2, uop_vs1,
                 want.pc);
        value_errors++;
      end
      if (uop_vd !== want.vd || uop_eew !== want.eew || uop_index !== want.index ||
          uop_last !== want.last) begin
        $display("FAIL %0t: pc %h got vd %0d eew %0d idx %0d last %b, want %0d %0d %0d %b",
                 $time, uop_pc, uop_vd, uop_eew, uop_index, uop_last,
                 want.vd, want.eew, want.index, want.last);
        value_errors++;
      end
    end
  endtask

  task automatic check_count(input string what, input int got, input int want);
    if (got != want) begin
      $display("FAIL %0t: %s pulses %0d, expected %0d", $time, what, got, want);
      illegal_errors++;
    end
  endtask

  // comparing process, mid-cycle where every output is settled
  always @(negedge clk) begin
    if (!reset) begin
      if (dispatch_illegal) got_disp_ill++;
      if (lsu_illegal) got_lsu_ill++;
      if (alu_illegal) got_alu_ill++;
      if (uop_valid && uop_pop) check_uop();
      next_pop = ({$random(seed)} % 4) != 0;   // mostly popping
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      #1;
      uop_pop = hold_pop ? 1'b0 : next_pop;
    end
  end

  initial begin
    logic [31:0] word;
    seed       = 22080;
    hold_pop   = 1'b0;
    next_pop   = 1'b0;
    pc_next    = 32'h0000_1000;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    inst_pc    = '0;
    vill       = 1'b0;
    vsew       = '0;
    vlmul      = '0;
    uop_pop    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle after reset
    repeat (12) begin
      next_cycle();
      if (inst_busy || uop_valid) begin
        $display("FAIL %0t: idle DUT shows inst_busy %b uop_valid %b", $time, inst_busy,
                 uop_valid);
        value_errors++;
      end
    end
    check_count("idle illegal", got_disp_ill + got_lsu_ill + got_alu_ill, 0);

    // unit-stride loads and stores over every width, sew and lmul
    for (int w = 0; w < 3; w++) begin
      for (int s = 0; s < 3; s++) begin
        for (int l = 0; l < 7; l++) begin
          word        = $random(seed);
          word[6:0]   = (l % 2 == 1) ? OPCODE_STORE_FP : OPCODE_LOAD_FP;
          word[14:12] = WIDTH_CODES[w];
          send_inst(word, 1'b0, 3'(s), LMUL_CODES[l]);
        end
      end
    end
    drain();

    // arithmetic over every sew and lmul
    for (int s = 0; s < 3; s++) begin
      for (int l = 0; l < 7; l++) begin
        word      = $random(seed);
        word[6:0] = OPCODE_OP_V;
        send_inst(word, 1'b0, 3'(s), LMUL_CODES[l]);
      end
    end
    drain();

    // illegal cases
    word = $random(seed);
    word[6:0] = OPCODE_LOAD_FP;
    word[14:12] = 3'b000;
    send_inst(word, 1'b1, 3'b000, 3'b000);
    send_inst(word, 1'b0, 3'b011, 3'b000);
    send_inst(word, 1'b0, 3'b000, 3'b100);
    send_inst(word, 1'b0, 3'b010, 3'b101);   // emul 1/32
    word[14:12] = 3'b110;
    send_inst(word, 1'b0, 3'b000, 3'b011);   // emul 32
    word[14:12] = 3'b001;
    send_inst(word, 1'b0, 3'b000, 3'b000);
    word[6:0] = OPCODE_OP_V;
    send_inst(word, 1'b1, 3'b001, 3'b001);
    send_inst(word, 1'b0, 3'b111, 3'b001);
    send_inst(word, 1'b0, 3'b000, 3'b100);
    word[6:0] = 7'b0110011;
    send_inst(word, 1'b0, 3'b000, 3'b000);
    word[6:0] = 7'b0000000;
    send_inst(word, 1'b0, 3'b000, 3'b000);
    drain();

    // mixed random stream
    repeat (60) begin
      word = $random(seed);
      case ({$random(seed)} % 3)
        0:       word[6:0] = OPCODE_LOAD_FP;
        1:       word[6:0] = OPCODE_STORE_FP;
        default: word[6:0] = OPCODE_OP_V;
      endcase
      if (word[6:0] != OPCODE_OP_V) word[14:12] = WIDTH_CODES[{$random(seed)} % 3];
      send_inst(word, ({$random(seed)} % 16) == 0, 3'({$random(seed)} % 3),
                3'({$random(seed)} % 8));
    end
    drain();

    // back-pressure with the queue full
    @(negedge clk);
    hold_pop = 1'b1;
    next_cycle();
    word      = $random(seed);
    word[6:0] = OPCODE_OP_V;
    send_inst(word, 1'b0, 3'b000, 3'b011);
    word      = $random(seed);
    word[6:0] = OPCODE_OP_V;
    send_inst(word, 1'b0, 3'b001, 3'b011);
    repeat (20) next_cycle();
    if (!inst_busy || !uop_valid) begin
      $display("FAIL %0t: stalled queue shows inst_busy %b uop_valid %b", $time, inst_busy,
               uop_valid);
      value_errors++;
    end
    @(negedge clk);
    hold_pop = 1'b0;
    next_cycle();
    drain();

    check_count("dispatch_illegal", got_disp_ill, exp_disp_ill);
    check_count("lsu_illegal", got_lsu_ill, exp_lsu_ill);
    check_count("alu_illegal", got_alu_ill, exp_alu_ill);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/rvv_pkg.sv
verilog/rvv_uop_pkg.sv
verilog/rvv_inst_dispatch.sv
verilog/rvv_decode_unit_lsu.sv
verilog/rvv_decode_unit_alu.sv
verilog/rvv_uop_arbiter.sv
verilog/rvv_uop_queue.sv
verilog/rvv_decode_top.sv
test/tb_rvv_decode.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rvv_decode -f all.f

./obj_dir/Vtb_rvv_decode | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
fi
exit 1
